/* core_isa_pkg.sv */
`default_nettype none

package core_isa_pkg;

    // Data path and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 12;

    // Instruction field positions
    localparam int OP_W    = 6;
    localparam int OP_LSB  = 26;
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int IMM_LSB = 10;

    // Major opcode in bits 31..26
    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 6'h00,
        OP_ADD_W  = 6'h01,
        OP_SUB_W  = 6'h02,
        OP_AND    = 6'h03,
        OP_OR     = 6'h04,
        OP_XOR    = 6'h05,
        OP_SLL_W  = 6'h06,
        OP_ADDI_W = 6'h07,
        OP_MUL_W  = 6'h08,
        OP_BEQ    = 6'h09,
        OP_BNE    = 6'h0a
    } opcode_e;

    // Unlisted encodings fall back to a no-op
    function automatic opcode_e decode_op(logic [OP_W-1:0] raw);
        case (raw)
            OP_ADD_W, OP_SUB_W, OP_AND, OP_OR, OP_XOR, OP_SLL_W,
            OP_ADDI_W, OP_MUL_W, OP_BEQ, OP_BNE: decode_op = opcode_e'(raw);
            default: decode_op = OP_NOP;
        endcase
    endfunction

endpackage

`default_nettype wire

/* core_pipe_pkg.sv */
`default_nettype none

package core_pipe_pkg;

    // Operand source picked at operand read
    typedef enum logic [1:0] {
        FWD_REG  = 2'd0,
        FWD_EXEC = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // Iterative multiplier sequencing
    typedef enum logic {
        MUL_IDLE = 1'b0,
        MUL_BUSY = 1'b1
    } mul_state_e;

endpackage

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [core_isa_pkg::XLEN-1:0]       rdata_a_o,
    output logic [core_isa_pkg::XLEN-1:0]       rdata_b_o,
    input  logic                                we_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_isa_pkg::XLEN-1:0]       wdata_i
);
    import core_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hard-wired to zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* decode_unit.sv */
`default_nettype none

module decode_unit (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                instr_valid_i,
    input  logic [core_isa_pkg::XLEN-1:0]       instr_i,
    input  logic [core_isa_pkg::XLEN-1:0]       pc_i,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
    input  logic [core_isa_pkg::XLEN-1:0]       rf_rdata_a_i,
    input  logic [core_isa_pkg::XLEN-1:0]       rf_rdata_b_i,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] src_a_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] src_b_o,
    output logic                                src_a_used_o,
    output logic                                src_b_used_o,
    input  core_pipe_pkg::fwd_sel_e             fwd_a_i,
    input  core_pipe_pkg::fwd_sel_e             fwd_b_i,
    input  logic [core_isa_pkg::XLEN-1:0]       exec_result_i,
    input  logic [core_isa_pkg::XLEN-1:0]       wb_result_i,
    input  logic                                stall_i,
    input  logic                                flush_i,
    output logic                                de_valid_o,
    output core_isa_pkg::opcode_e               de_op_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] de_rd_o,
    output logic [core_isa_pkg::XLEN-1:0]       de_pc_o,
    output logic [core_isa_pkg::XLEN-1:0]       de_a_o,
    output logic [core_isa_pkg::XLEN-1:0]       de_b_o,
    output logic [core_isa_pkg::XLEN-1:0]       de_imm_o
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [IMM_W-1:0]      imm12;
    logic                  is_branch;
    logic [XLEN-1:0]       opnd_a;
    logic [XLEN-1:0]       opnd_b;

    assign op    = decode_op(instr_i[OP_LSB +: OP_W]);
    assign rd    = instr_i[RD_LSB +: REG_ADDR_W];
    assign rj    = instr_i[RJ_LSB +: REG_ADDR_W];
    assign rk    = instr_i[RK_LSB +: REG_ADDR_W];
    assign imm12 = instr_i[IMM_LSB +: IMM_W];

    // Branches compare rj against rd, so rd takes the second read port
    assign is_branch    = (op == OP_BEQ) || (op == OP_BNE);
    assign src_a_o      = rj;
    assign src_b_o      = is_branch ? rd : rk;
    assign src_a_used_o = (op != OP_NOP);
    assign src_b_used_o = (op != OP_NOP) && (op != OP_ADDI_W);
    assign rf_raddr_a_o = src_a_o;
    assign rf_raddr_b_o = src_b_o;

    always_comb begin
        case (fwd_a_i)
            FWD_EXEC: opnd_a = exec_result_i;
            FWD_WB:   opnd_a = wb_result_i;
            default:  opnd_a = rf_rdata_a_i;
        endcase
        case (fwd_b_i)
            FWD_EXEC: opnd_b = exec_result_i;
            FWD_WB:   opnd_b = wb_result_i;
            default:  opnd_b = rf_rdata_b_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            de_valid_o <= 1'b0;
        end else if (!stall_i) begin
            de_valid_o <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            de_op_o  <= op;
            de_rd_o  <= rd;
            de_pc_o  <= pc_i;
            de_a_o   <= opnd_a;
            de_b_o   <= opnd_b;
            de_imm_o <= {{(XLEN-IMM_W){imm12[IMM_W-1]}}, imm12};
        end
    end

    // A held instruction must reach execute unchanged once the multiply ends
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        stall_i |=> $stable(de_valid_o) && $stable(de_op_o) && $stable(de_pc_o)
                    && $stable(de_a_o) && $stable(de_b_o));

endmodule

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

module exec_unit #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                de_valid_i,
    input  core_isa_pkg::opcode_e               de_op_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] de_rd_i,
    input  logic [core_isa_pkg::XLEN-1:0]       de_pc_i,
    input  logic [core_isa_pkg::XLEN-1:0]       de_a_i,
    input  logic [core_isa_pkg::XLEN-1:0]       de_b_i,
    input  logic [core_isa_pkg::XLEN-1:0]       de_imm_i,
    input  logic                                stall_i,
    output logic                                exec_valid_o,
    output logic                                exec_we_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] exec_rd_o,
    output logic [core_isa_pkg::XLEN-1:0]       exec_result_o,
    output logic                                mul_busy_o,
    output logic                                branch_taken_o,
    output logic [core_isa_pkg::XLEN-1:0]       branch_target_o,
    output logic                                wb_valid_o,
    output logic [core_isa_pkg::XLEN-1:0]       wb_pc_o,
    output logic                                wb_wen_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] wb_wnum_o,
    output logic [core_isa_pkg::XLEN-1:0]       wb_wdata_o
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int MUL_STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W     = $clog2(MUL_STEPS);
    localparam int SHAMT_W   = $clog2(XLEN);

    mul_state_e      mul_state;
    logic [CNT_W-1:0] mul_cnt;
    logic [XLEN-1:0] mul_acc;
    logic [XLEN-1:0] mul_mcand;
    logic [XLEN-1:0] mul_mplier;
    logic [XLEN-1:0] cur_acc;
    logic [XLEN-1:0] cur_mcand;
    logic [XLEN-1:0] cur_mplier;
    logic [XLEN-1:0] step_sum;
    logic            mul_last;
    logic            writes_rd;
    logic            opnd_eq;

    // First step works on the fresh operands, later ones on the saved state
    assign cur_acc    = (mul_state == MUL_IDLE) ? '0 : mul_acc;
    assign cur_mcand  = (mul_state == MUL_IDLE) ? de_a_i : mul_mcand;
    assign cur_mplier = (mul_state == MUL_IDLE) ? de_b_i : mul_mplier;

    always_comb begin
        step_sum = cur_acc;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (cur_mplier[i]) begin
                step_sum = step_sum + (cur_mcand << i);
            end
        end
    end

    assign mul_last   = (mul_state == MUL_BUSY) && (mul_cnt == CNT_W'(MUL_STEPS - 1));
    assign mul_busy_o = de_valid_i && (de_op_i == OP_MUL_W) && !mul_last;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mul_state <= MUL_IDLE;
            mul_cnt   <= '0;
        end else if (mul_state == MUL_IDLE) begin
            if (de_valid_i && (de_op_i == OP_MUL_W)) begin
                mul_state <= MUL_BUSY;
                mul_cnt   <= CNT_W'(1);
            end
        end else if (mul_last) begin
            mul_state <= MUL_IDLE;
            mul_cnt   <= '0;
        end else begin
            mul_cnt <= mul_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_busy_o) begin
            mul_acc    <= step_sum;
            mul_mcand  <= cur_mcand << MUL_BITS_PER_CYCLE;
            mul_mplier <= cur_mplier >> MUL_BITS_PER_CYCLE;
        end
    end

    always_comb begin
        writes_rd = 1'b1;
        case (de_op_i)
            OP_ADD_W:  exec_result_o = de_a_i + de_b_i;
            OP_SUB_W:  exec_result_o = de_a_i - de_b_i;
            OP_AND:    exec_result_o = de_a_i & de_b_i;
            OP_OR:     exec_result_o = de_a_i | de_b_i;
            OP_XOR:    exec_result_o = de_a_i ^ de_b_i;
            OP_SLL_W:  exec_result_o = de_a_i << de_b_i[SHAMT_W-1:0];
            OP_ADDI_W: exec_result_o = de_a_i + de_imm_i;
            OP_MUL_W:  exec_result_o = step_sum;
            default: begin
                exec_result_o = '0;
                writes_rd     = 1'b0;
            end
        endcase
    end

    assign exec_valid_o = de_valid_i;
    assign exec_rd_o    = de_rd_i;
    assign exec_we_o    = de_valid_i && writes_rd && (de_rd_i != '0);

    // Branch offset counts instruction words
    assign opnd_eq         = (de_a_i == de_b_i);
    assign branch_taken_o  = ((de_op_i == OP_BEQ) && opnd_eq) || ((de_op_i == OP_BNE) && !opnd_eq);
    assign branch_target_o = de_pc_i + (de_imm_i << 2);

    // Multiply in progress sends bubbles to writeback
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_wen_o   <= 1'b0;
        end else begin
            wb_valid_o <= de_valid_i && !stall_i;
            wb_wen_o   <= exec_we_o && !stall_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o    <= de_pc_i;
        wb_wnum_o  <= de_rd_i;
        wb_wdata_o <= exec_result_o;
    end

    a_wen_not_r0: assert property (@(posedge clk) disable iff (reset_i)
        wb_wen_o |-> (wb_wnum_o != '0));

    a_wen_has_valid: assert property (@(posedge clk) disable iff (reset_i)
        wb_wen_o |-> wb_valid_o);

endmodule

`default_nettype wire

/* pipe_ctrl.sv */
`default_nettype none

module pipe_ctrl (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] src_a_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] src_b_i,
    input  logic                                src_a_used_i,
    input  logic                                src_b_used_i,
    input  logic                                exec_valid_i,
    input  logic                                exec_we_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] exec_rd_i,
    input  logic                                wb_we_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                                mul_busy_i,
    input  logic                                branch_taken_i,
    output core_pipe_pkg::fwd_sel_e             fwd_a_o,
    output core_pipe_pkg::fwd_sel_e             fwd_b_o,
    output logic                                stall_o,
    output logic                                flush_o
);
    import core_pipe_pkg::*;

    // Youngest producer wins and r0 never forwards
    function automatic fwd_sel_e pick_src(
        input logic                                used,
        input logic [core_isa_pkg::REG_ADDR_W-1:0] src
    );
        if (!used || (src == '0)) begin
            pick_src = FWD_REG;
        end else if (exec_valid_i && exec_we_i && (exec_rd_i == src)) begin
            pick_src = FWD_EXEC;
        end else if (wb_we_i && (wb_rd_i == src)) begin
            pick_src = FWD_WB;
        end else begin
            pick_src = FWD_REG;
        end
    endfunction

    always_comb begin
        fwd_a_o = pick_src(src_a_used_i, src_a_i);
        fwd_b_o = pick_src(src_b_used_i, src_b_i);
    end

    assign stall_o = mul_busy_i;
    assign flush_o = exec_valid_i && branch_taken_i;

    // A redirect needs the pipeline moving, so it cannot meet a multiply stall
    a_no_stall_flush: assert property (@(posedge clk) disable iff (reset_i)
        !(stall_o && flush_o));

endmodule

`default_nettype wire

/* core_top.sv */
`default_nettype none

module core_top #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           instr_valid_i,
    input  logic [core_isa_pkg::XLEN-1:0]  instr_i,
    input  logic [core_isa_pkg::XLEN-1:0]  pc_i,
    output logic                           stall_o,
    output logic                           redirect_o,
    output logic [core_isa_pkg::XLEN-1:0]  redirect_pc_o,
    output logic                           wb_valid_o,
    output logic [core_isa_pkg::XLEN-1:0]  wb_pc_o,
    output logic                           wb_wen_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] wb_wnum_o,
    output logic [core_isa_pkg::XLEN-1:0]  wb_wdata_o
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    // Decode <-> register file
    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic [XLEN-1:0]       rf_rdata_a;
    logic [XLEN-1:0]       rf_rdata_b;

    // Hazard information toward control
    logic [REG_ADDR_W-1:0] src_a;
    logic [REG_ADDR_W-1:0] src_b;
    logic                  src_a_used;
    logic                  src_b_used;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;

    // Decode-to-execute register
    logic                  de_valid;
    opcode_e               de_op;
    logic [REG_ADDR_W-1:0] de_rd;
    logic [XLEN-1:0]       de_pc;
    logic [XLEN-1:0]       de_a;
    logic [XLEN-1:0]       de_b;
    logic [XLEN-1:0]       de_imm;

    // Execute stage status
    logic                  exec_valid;
    logic                  exec_we;
    logic [REG_ADDR_W-1:0] exec_rd;
    logic [XLEN-1:0]       exec_result;
    logic                  mul_busy;
    logic                  branch_taken;

    decode_unit u_decode (
        .clk(clk), .reset_i(reset_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
        .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
        .src_a_o(src_a), .src_b_o(src_b),
        .src_a_used_o(src_a_used), .src_b_used_o(src_b_used),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .exec_result_i(exec_result), .wb_result_i(wb_wdata_o),
        .stall_i(stall_o), .flush_i(redirect_o),
        .de_valid_o(de_valid), .de_op_o(de_op), .de_rd_o(de_rd), .de_pc_o(de_pc),
        .de_a_o(de_a), .de_b_o(de_b), .de_imm_o(de_imm)
    );

    reg_file u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b),
        .we_i(wb_wen_o), .waddr_i(wb_wnum_o), .wdata_i(wb_wdata_o)
    );

    exec_unit #(
        .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
    ) u_exec (
        .clk(clk), .reset_i(reset_i),
        .de_valid_i(de_valid), .de_op_i(de_op), .de_rd_i(de_rd), .de_pc_i(de_pc),
        .de_a_i(de_a), .de_b_i(de_b), .de_imm_i(de_imm), .stall_i(stall_o),
        .exec_valid_o(exec_valid), .exec_we_o(exec_we), .exec_rd_o(exec_rd),
        .exec_result_o(exec_result), .mul_busy_o(mul_busy),
        .branch_taken_o(branch_taken), .branch_target_o(redirect_pc_o),
        .wb_valid_o(wb_valid_o), .wb_pc_o(wb_pc_o), .wb_wen_o(wb_wen_o),
        .wb_wnum_o(wb_wnum_o), .wb_wdata_o(wb_wdata_o)
    );

    pipe_ctrl u_pipe_ctrl (
        .clk(clk), .reset_i(reset_i),
        .src_a_i(src_a), .src_b_i(src_b),
        .src_a_used_i(src_a_used), .src_b_used_i(src_b_used),
        .exec_valid_i(exec_valid), .exec_we_i(exec_we), .exec_rd_i(exec_rd),
        .wb_we_i(wb_wen_o), .wb_rd_i(wb_wnum_o),
        .mul_busy_i(mul_busy), .branch_taken_i(branch_taken),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b),
        .stall_o(stall_o), .flush_o(redirect_o)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker #(
    parameter int          NUM_ROWS = 1,
    parameter logic [31:0] PC_BASE  = '0
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        instr_valid_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        wb_valid_i,
    input  logic [31:0] wb_pc_i,
    input  logic        wb_wen_i,
    input  logic [4:0]  wb_wnum_i,
    input  logic [31:0] wb_wdata_i,
    input  logic [127:0] row_name_i [NUM_ROWS],
    input  logic [31:0] row_instr_i [NUM_ROWS],
    input  logic        row_squash_i [NUM_ROWS],
    output logic        done_o,
    output int          err_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import core_isa_pkg::*;

    logic [XLEN-1:0] shadow [NUM_REGS];
    logic [XLEN-1:0] redirects [$];
    int              row_idx = 0;
    int              pass_count = 0;
    logic            first_taken = 1'b0;
    logic            idle_bad = 1'b0;
    logic            idle_reported = 1'b0;
    logic            stall_seen = 1'b0;

    // Prediction of the row being checked
    logic [5:0]            op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       target;
    logic                  wen;
    logic                  is_br;
    logic                  is_mul;
    logic                  taken;

    initial begin
        done_o      = 1'b0;
        err_count_o = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
    end

    task automatic predict_row(input int idx);
        logic [XLEN-1:0] instr;
        instr  = row_instr_i[idx];
        op     = instr[OP_LSB +: OP_W];
        rd     = instr[RD_LSB +: REG_ADDR_W];
        rj     = instr[RJ_LSB +: REG_ADDR_W];
        rk     = instr[RK_LSB +: REG_ADDR_W];
        imm    = {{(XLEN - IMM_W){instr[IMM_LSB + IMM_W - 1]}}, instr[IMM_LSB +: IMM_W]};
        pc     = PC_BASE + XLEN'(4 * idx);
        is_br  = (op == OP_BEQ) || (op == OP_BNE);
        a      = shadow[rj];
        b      = is_br ? shadow[rd] : shadow[rk];
        wen    = 1'b1;
        is_mul = 1'b0;
        taken  = 1'b0;
        result = '0;
        case (op)
            OP_ADD_W:  result = a + b;
            OP_SUB_W:  result = a - b;
            OP_AND:    result = a & b;
            OP_OR:     result = a | b;
            OP_XOR:    result = a ^ b;
            OP_SLL_W:  result = a << b[4:0];
            OP_ADDI_W: result = a + imm;
            OP_MUL_W: begin
                result = a * b;
                is_mul = 1'b1;
            end
            OP_BEQ: begin
                wen   = 1'b0;
                taken = (a == b);
            end
            OP_BNE: begin
                wen   = 1'b0;
                taken = (a != b);
            end
            default: wen = 1'b0;
        endcase
        if (rd == '0) begin
            wen = 1'b0;
        end
        target = pc + (imm << 2);
    endtask

    task automatic skip_squashed();
        while (row_idx < NUM_ROWS && row_squash_i[row_idx]) begin
            $display("squashed %s, no commit expected", row_name_i[row_idx]);
            row_idx++;
        end
    endtask

    task automatic check_commit();
        logic ok;
        skip_squashed();
        if (row_idx >= NUM_ROWS) begin
            $display("Unexpected commit at pc %h after the last row", wb_pc_i);
            err_count_o++;
            return;
        end
        predict_row(row_idx);
        ok = 1'b0;
        if (wb_pc_i !== pc) begin
            $display("ERR %s pc expected %h actual %h", row_name_i[row_idx], pc, wb_pc_i);
        end else if (wb_wen_i !== wen) begin
            $display("ERR %s wen expected %b actual %b", row_name_i[row_idx], wen, wb_wen_i);
        end else if (wen && wb_wnum_i !== rd) begin
            $display("ERR %s wnum expected %0d actual %0d", row_name_i[row_idx], rd, wb_wnum_i);
        end else if (wen && wb_wdata_i !== result) begin
            $display("ERR %s wdata expected %h actual %h",
                     row_name_i[row_idx], result, wb_wdata_i);
        end else if (is_mul && !stall_seen) begin
            $display("%s: stall_o never went high for the multiply", row_name_i[row_idx]);
        end else if (taken && redirects.size() == 0) begin
            $display("%s: taken branch gave no redirect pulse", row_name_i[row_idx]);
        end else if (taken && redirects[0] !== target) begin
            $display("ERR %s redirect_pc expected %h actual %h",
                     row_name_i[row_idx], target, redirects[0]);
        end else if (!taken && redirects.size() != 0) begin
            $display("%s: redirect pulse without a taken branch", row_name_i[row_idx]);
        end else begin
            ok = 1'b1;
            $display("PASS %s", row_name_i[row_idx]);
        end
        if (ok) begin
            pass_count++;
        end else begin
            err_count_o++;
        end
        if (redirects.size() != 0 && taken) begin
            void'(redirects.pop_front());
        end
        if (wen) begin
            shadow[rd] = result;
        end
        stall_seen = 1'b0;
        row_idx++;
        skip_squashed();
        if (row_idx >= NUM_ROWS) begin
            $display("Rows checked: %0d passed, %0d failed", pass_count, err_count_o);
            done_o = 1'b1;
        end
    endtask

    // Input is stable at the rising edge
    always @(posedge clk) begin
        if (!reset_i && instr_valid_i) begin
            first_taken <= 1'b1;
        end
    end

    // DUT outputs settle mid-cycle, so everything is sampled on the falling edge
    always @(negedge clk) begin
        if (!first_taken) begin
            if (wb_valid_i !== 1'b0 || redirect_i !== 1'b0 || stall_i !== 1'b0) begin
                idle_bad = 1'b1;
            end
        end else if (!idle_reported) begin
            idle_reported = 1'b1;
            if (idle_bad) begin
                $display("wb_valid_o, redirect_o or stall_o was not low before the first row");
                err_count_o++;
            end else begin
                $display("PASS idle_after_reset");
                pass_count++;
            end
        end
        if (wb_valid_i === 1'b1 && !done_o) begin
            check_commit();
        end
        if (redirect_i === 1'b1) begin
            redirects.push_back(redirect_pc_i);
        end
        if (stall_i === 1'b1) begin
            stall_seen = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_core.sv */
`default_nettype none

module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_isa_pkg::*;

    localparam int              NUM_ROWS    = 25;
    localparam logic [XLEN-1:0] PC_BASE     = 32'h0000_1000;
    localparam int              CYCLE_LIMIT = NUM_ROWS * (XLEN / 4 + 4) + 50;

    logic                  clk;
    logic                  reset_i;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic [XLEN-1:0]       pc_i;
    logic                  stall_o;
    logic                  redirect_o;
    logic [XLEN-1:0]       redirect_pc_o;
    logic                  wb_valid_o;
    logic [XLEN-1:0]       wb_pc_o;
    logic                  wb_wen_o;
    logic [REG_ADDR_W-1:0] wb_wnum_o;
    logic [XLEN-1:0]       wb_wdata_o;

    // Stimulus table
    logic [127:0]    row_name   [NUM_ROWS];
    logic [XLEN-1:0] row_instr  [NUM_ROWS];
    logic            row_squash [NUM_ROWS];
    int              n_rows = 0;

    int   seed = 32'hdd6d_2585;
    int   cycle_cnt = 0;
    logic all_done;
    int   err_count;

    core_top #(
        .MUL_BITS_PER_CYCLE(4)
    ) dut (
        .clk(clk), .reset_i(reset_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .stall_o(stall_o), .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
        .wb_valid_o(wb_valid_o), .wb_pc_o(wb_pc_o), .wb_wen_o(wb_wen_o),
        .wb_wnum_o(wb_wnum_o), .wb_wdata_o(wb_wdata_o)
    );

    tb_checker #(
        .NUM_ROWS(NUM_ROWS),
        .PC_BASE(PC_BASE)
    ) u_checker (
        .clk(clk), .reset_i(reset_i), .instr_valid_i(instr_valid_i),
        .stall_i(stall_o), .redirect_i(redirect_o), .redirect_pc_i(redirect_pc_o),
        .wb_valid_i(wb_valid_o), .wb_pc_i(wb_pc_o), .wb_wen_i(wb_wen_o),
        .wb_wnum_i(wb_wnum_o), .wb_wdata_i(wb_wdata_o),
        .row_name_i(row_name), .row_instr_i(row_instr), .row_squash_i(row_squash),
        .done_o(all_done), .err_count_o(err_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Field layout: op[31:26], imm12 or rk at [21:10], rj[9:5], rd[4:0]
    function automatic logic [XLEN-1:0] pack_instr(input logic [5:0] op,
                                                   input logic [4:0] rd,
                                                   input logic [4:0] rj,
                                                   input logic [11:0] hi);
        return {op, 4'b0000, hi, rj, rd};
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    task automatic add_row(input logic [127:0] name, input logic [XLEN-1:0] instr,
                           input logic squash);
        row_name[n_rows]   = name;
        row_instr[n_rows]  = instr;
        row_squash[n_rows] = squash;
        n_rows++;
    endtask

    // Ends the run if the commits never complete
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: rows still pending after %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;

        // Dependent ALU chain
        add_row("addi_r1", pack_instr(OP_ADDI_W, 5'd1, 5'd0, rand_imm()), 1'b0);
        add_row("addi_r2", pack_instr(OP_ADDI_W, 5'd2, 5'd0, rand_imm()), 1'b0);
        add_row("add_r3", pack_instr(OP_ADD_W, 5'd3, 5'd1, 12'd2), 1'b0);
        add_row("sub_r4", pack_instr(OP_SUB_W, 5'd4, 5'd3, 12'd1), 1'b0);
        add_row("and_r5", pack_instr(OP_AND, 5'd5, 5'd4, 12'd3), 1'b0);
        add_row("or_r6", pack_instr(OP_OR, 5'd6, 5'd5, 12'd2), 1'b0);
        add_row("xor_r7", pack_instr(OP_XOR, 5'd7, 5'd6, 12'd4), 1'b0);
        add_row("sll_r8", pack_instr(OP_SLL_W, 5'd8, 5'd7, 12'd2), 1'b0);
        add_row("addi_r9", pack_instr(OP_ADDI_W, 5'd9, 5'd8, rand_imm()), 1'b0);
        // Branches, taken ones squash the next row
        add_row("bne_nt", pack_instr(OP_BNE, 5'd3, 5'd3, rand_imm()), 1'b0);
        add_row("add_r10", pack_instr(OP_ADD_W, 5'd10, 5'd9, 12'd1), 1'b0);
        add_row("beq_tk", pack_instr(OP_BEQ, 5'd10, 5'd10, rand_imm()), 1'b0);
        add_row("sq_addi", pack_instr(OP_ADDI_W, 5'd11, 5'd0, rand_imm()), 1'b1);
        add_row("addi_r11", pack_instr(OP_ADDI_W, 5'd11, 5'd0, rand_imm() | 12'h001), 1'b0);
        add_row("bne_tk", pack_instr(OP_BNE, 5'd0, 5'd11, rand_imm()), 1'b0);
        add_row("sq_add", pack_instr(OP_ADD_W, 5'd1, 5'd1, 12'd1), 1'b1);
        // Multiplies and their consumers
        add_row("mul_r12", pack_instr(OP_MUL_W, 5'd12, 5'd3, 12'd9), 1'b0);
        add_row("mul_dep", pack_instr(OP_ADD_W, 5'd13, 5'd12, 12'd1), 1'b0);
        add_row("mul_r14", pack_instr(OP_MUL_W, 5'd14, 5'd12, 12'd13), 1'b0);
        add_row("sub_r15", pack_instr(OP_SUB_W, 5'd15, 5'd14, 12'd13), 1'b0);
        // r0 and an unlisted opcode
        add_row("wr_r0", pack_instr(OP_ADDI_W, 5'd0, 5'd1, rand_imm()), 1'b0);
        add_row("rd_r0", pack_instr(OP_OR, 5'd16, 5'd0, 12'd0), 1'b0);
        add_row("bad_op", pack_instr(6'h3f, 5'd17, 5'd1, 12'd2), 1'b0);
        add_row("after_nop", pack_instr(OP_ADD_W, 5'd18, 5'd17, 12'd1), 1'b0);
        add_row("xor_r19", pack_instr(OP_XOR, 5'd19, 5'd18, 12'd16), 1'b0);

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // One row per falling edge, held while the core stalls
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            instr_valid_i = 1'b1;
            instr_i       = row_instr[i];
            pc_i          = PC_BASE + XLEN'(4 * i);
            while (stall_o) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = '0;

        while (!all_done) begin
            @(negedge clk);
        end
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
core_isa_pkg.sv
core_pipe_pkg.sv
reg_file.sv
decode_unit.sv
exec_unit.sv
pipe_ctrl.sv
core_top.sv
tb_checker.sv
tb_core.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_core
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := run.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The log decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
